// File: rtl/mem_pkg.sv
`default_nettype none

// ----------------------------------------
// Shared widths and types for the memory stage.
// ----------------------------------------

package mem_pkg;

        // Width of the status flags word (CPSR image).
        localparam int FLAG_WDT = 32;

        // Number of physical registers in the register file.
        localparam int PHY_REGS = 46;

        // Width of a physical register index.
        localparam int REG_IDX_W = $clog2(PHY_REGS);

        // ----------------------------------------
        // Vector types.
        // ----------------------------------------

        // Data word: ALU result, PC, read data, srcdest value.
        typedef logic [31:0] word_t;

        // Status flags.
        typedef logic [FLAG_WDT-1:0] flags_t;

        // Physical register index.
        typedef logic [REG_IDX_W-1:0] reg_idx_t;

        // Byte offset within a word, low address bits.
        typedef logic [1:0] byte_off_t;

        // Memory fault code from the data cache.
        typedef logic [1:0] fault_t;

        // ----------------------------------------
        // Access kind.
        // ----------------------------------------

        // Size and signedness of a load.
        // Word is the default when no size strobe is set.
        typedef enum logic [2:0]
        {
                ACC_WORD,
                ACC_UBYTE,
                ACC_SBYTE,
                ACC_UHALF,
                ACC_SHALF
        } access_kind_t;

endpackage

`default_nettype wire

// File: rtl/mem_lane_if.sv
`default_nettype none

// Enables and decoded load information from the control module
// to both datapath modules.
interface mem_lane_if;

        // Payload and read data load enable.
        // High only outside reset, clear and stall.
        logic                   capture;

        // Retiming enable for the load information.
        // High whenever the cache is not stalling.
        logic                   retime;

        // Load flag of the incoming instruction.
        logic                   load;

        // Decoded size and signedness.
        mem_pkg::access_kind_t  kind;

        // Byte offset of the access.
        mem_pkg::byte_off_t     offset;

        // Control side drives everything.
        modport ctrl
        (
                output capture,
                output retime,
                output load,
                output kind,
                output offset
        );

        // Datapath side only listens.
        modport lane
        (
                input capture,
                input retime,
                input load,
                input kind,
                input offset
        );

endinterface

`default_nettype wire

// File: rtl/mem_stage_ctrl.sv
`default_nettype none

// Pipeline control of the memory stage.
// Reset, clear and stall are tested here and nowhere else.
module mem_stage_ctrl
(
        // Clock and reset.
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Pipeline controls.
        input  logic                    i_clear,
        input  logic                    i_stall,

        // Valid and exception flags from the ALU stage.
        input  logic                    i_valid,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        input  logic                    i_swi,
        input  logic                    i_instr_abort,
        input  logic                    i_und,
        input  mem_pkg::fault_t         i_mem_fault,

        // Memory access description.
        input  logic                    i_mem_load,
        input  mem_pkg::byte_off_t      i_mem_addr,
        input  logic                    i_sbyte,
        input  logic                    i_ubyte,
        input  logic                    i_shalf,
        input  logic                    i_uhalf,

        // Registered valid and exceptions to writeback.
        output logic                    o_valid,
        output logic                    o_irq,
        output logic                    o_fiq,
        output logic                    o_swi,
        output logic                    o_instr_abort,
        output logic                    o_und,
        output mem_pkg::fault_t         o_mem_fault,

        // Enables and load info to the datapaths.
        mem_lane_if.ctrl                lane
);

// ----------------------------------------
// Datapath enables.
// ----------------------------------------

// Payload moves only on a clean cycle.
assign lane.capture = !i_reset && !i_clear && !i_stall;

// Retiming follows the stall alone.
assign lane.retime  = !i_stall;

// Load info passes straight through.
assign lane.load    = i_mem_load;
assign lane.offset  = i_mem_addr;

// ----------------------------------------
// Size strobe decode.
// ----------------------------------------

// Priority: ubyte, sbyte, shalf, uhalf, then word.
always_comb
begin
        if ( i_ubyte )
                lane.kind = mem_pkg::ACC_UBYTE;
        else if ( i_sbyte )
                lane.kind = mem_pkg::ACC_SBYTE;
        else if ( i_shalf )
                lane.kind = mem_pkg::ACC_SHALF;
        else if ( i_uhalf )
                lane.kind = mem_pkg::ACC_UHALF;
        else
                lane.kind = mem_pkg::ACC_WORD;
end

// ----------------------------------------
// Valid and exception registers.
// ----------------------------------------

always_ff @ (posedge i_clk)
begin
        if ( i_reset || i_clear )
        begin
                // Invalidate and drop all pending exceptions.
                o_valid       <= 1'b0;
                o_irq         <= 1'b0;
                o_fiq         <= 1'b0;
                o_swi         <= 1'b0;
                o_instr_abort <= 1'b0;
                o_und         <= 1'b0;
                o_mem_fault   <= '0;
        end
        else if ( i_stall )
        begin
                // Bubble out, exceptions hold.
                o_valid <= 1'b0;
        end
        else
        begin
                o_valid       <= i_valid;
                o_irq         <= i_irq;
                o_fiq         <= i_fiq;
                o_swi         <= i_swi;
                o_instr_abort <= i_instr_abort;
                o_und         <= i_und;
                o_mem_fault   <= i_mem_fault;
        end
end

endmodule

`default_nettype wire

// File: rtl/mem_payload_regs.sv
`default_nettype none

// Payload register bank of the memory stage.
// Wide data fields without reset, loaded under capture.
module mem_payload_regs
(
        // Clock.
        input  logic                    i_clk,

        // Payload from the ALU stage.
        input  mem_pkg::word_t          i_alu_result,
        input  mem_pkg::flags_t         i_flags,
        input  mem_pkg::word_t          i_pc_plus_8,
        input  mem_pkg::reg_idx_t       i_dest_idx,
        input  mem_pkg::reg_idx_t       i_mem_srcdest_idx,

        // Registered payload to writeback.
        output mem_pkg::word_t          o_alu_result,
        output mem_pkg::flags_t         o_flags,
        output mem_pkg::word_t          o_pc_plus_8,
        output mem_pkg::reg_idx_t       o_dest_idx,
        output mem_pkg::reg_idx_t       o_mem_srcdest_idx,
        output logic                    o_mem_load,

        // Enables and load info from the control module.
        mem_lane_if.lane                lane
);

// ----------------------------------------
// Payload capture.
// ----------------------------------------

always_ff @ (posedge i_clk)
begin
        if ( lane.capture )
        begin
                // ALU result and its flags.
                o_alu_result      <= i_alu_result;
                o_flags           <= i_flags;

                // PC image for exception return.
                o_pc_plus_8       <= i_pc_plus_8;

                // Writeback target for the ALU result.
                o_dest_idx        <= i_dest_idx;

                // Writeback target for load data.
                o_mem_srcdest_idx <= i_mem_srcdest_idx;

                // Tells writeback which port carries load data.
                o_mem_load        <= lane.load;
        end
        // Otherwise hold. Stall, clear and reset all land here.
end

endmodule

`default_nettype wire

// File: rtl/load_align.sv
`default_nettype none

// Load data alignment.
// Cache always returns a full word; the addressed byte or half is
// moved to the low bits and extended here.
module load_align
(
        // Clock.
        input  logic                    i_clk,

        // Word from the data cache.
        input  mem_pkg::word_t          i_mem_rd_data,

        // Store / source value, used when not a load.
        input  mem_pkg::word_t          i_mem_srcdest_value,

        // Aligned result to writeback.
        output mem_pkg::word_t          o_mem_rd_data,

        // Enables and load info from the control module.
        mem_lane_if.lane                lane
);

// Captured cache word.
mem_pkg::word_t          rd_data_q;

// Retimed load information.
logic                    load_q;
mem_pkg::access_kind_t   kind_q;
mem_pkg::byte_off_t      offset_q;
mem_pkg::word_t          srcdest_q;

// Selected lanes.
logic [7:0]              sel_byte;
logic [15:0]             sel_half;

// ----------------------------------------
// Registers.
// ----------------------------------------

// Read word moves with the payload.
always_ff @ (posedge i_clk)
begin
        if ( lane.capture )
                rd_data_q <= i_mem_rd_data;
end

// Load info is retimed on every non-stalled edge.
always_ff @ (posedge i_clk)
begin
        if ( lane.retime )
        begin
                load_q    <= lane.load;
                kind_q    <= lane.kind;
                offset_q  <= lane.offset;
                srcdest_q <= i_mem_srcdest_value;
        end
end

// ----------------------------------------
// Lane select.
// ----------------------------------------

// Byte at the access offset.
always_comb
begin
        case ( offset_q )
        2'd0:    sel_byte = rd_data_q[7:0];
        2'd1:    sel_byte = rd_data_q[15:8];
        2'd2:    sel_byte = rd_data_q[23:16];
        default: sel_byte = rd_data_q[31:24];
        endcase
end

// Half picked by offset bit 1; bit 0 is ignored.
assign sel_half = offset_q[1] ? rd_data_q[31:16] : rd_data_q[15:0];

// ----------------------------------------
// Extension.
// ----------------------------------------

always_comb
begin
        if ( !load_q )
        begin
                // Not a load, pass the source value on.
                o_mem_rd_data = srcdest_q;
        end
        else
        begin
                case ( kind_q )
                mem_pkg::ACC_UBYTE: o_mem_rd_data = {24'd0, sel_byte};
                mem_pkg::ACC_SBYTE: o_mem_rd_data = {{24{sel_byte[7]}}, sel_byte};
                mem_pkg::ACC_UHALF: o_mem_rd_data = {16'd0, sel_half};
                mem_pkg::ACC_SHALF: o_mem_rd_data = {{16{sel_half[15]}}, sel_half};
                default:            o_mem_rd_data = rd_data_q; // Word.
                endcase
        end
end

endmodule

`default_nettype wire

// File: rtl/mem_stage_top.sv
`default_nettype none

// Memory access stage, between the ALU stage and writeback.
module mem_stage_top
(
        // Clock and reset.
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Pipeline controls.
        input  logic                    i_clear,
        input  logic                    i_stall,

        // Valid and exceptions in.
        input  logic                    i_valid,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        input  logic                    i_swi,
        input  logic                    i_instr_abort,
        input  logic                    i_und,
        input  mem_pkg::fault_t         i_mem_fault,

        // Access description.
        input  logic                    i_mem_load,
        input  mem_pkg::byte_off_t      i_mem_addr,
        input  logic                    i_sbyte,
        input  logic                    i_ubyte,
        input  logic                    i_shalf,
        input  logic                    i_uhalf,

        // Payload in.
        input  mem_pkg::word_t          i_alu_result,
        input  mem_pkg::flags_t         i_flags,
        input  mem_pkg::word_t          i_pc_plus_8,
        input  mem_pkg::reg_idx_t       i_dest_idx,
        input  mem_pkg::reg_idx_t       i_mem_srcdest_idx,
        input  mem_pkg::word_t          i_mem_rd_data,
        input  mem_pkg::word_t          i_mem_srcdest_value,

        // Valid and exceptions out.
        output logic                    o_valid,
        output logic                    o_irq,
        output logic                    o_fiq,
        output logic                    o_swi,
        output logic                    o_instr_abort,
        output logic                    o_und,
        output mem_pkg::fault_t         o_mem_fault,

        // Payload out.
        output mem_pkg::word_t          o_alu_result,
        output mem_pkg::flags_t         o_flags,
        output mem_pkg::word_t          o_pc_plus_8,
        output mem_pkg::reg_idx_t       o_dest_idx,
        output mem_pkg::reg_idx_t       o_mem_srcdest_idx,
        output logic                    o_mem_load,
        output mem_pkg::word_t          o_mem_rd_data
);

// Enable and load info bus, control to datapaths.
mem_lane_if lane_bus ();

// ----------------------------------------
// Control.
// ----------------------------------------

mem_stage_ctrl u_ctrl
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_clear        (i_clear),
        .i_stall        (i_stall),
        .i_valid        (i_valid),
        .i_irq          (i_irq),
        .i_fiq          (i_fiq),
        .i_swi          (i_swi),
        .i_instr_abort  (i_instr_abort),
        .i_und          (i_und),
        .i_mem_fault    (i_mem_fault),
        .i_mem_load     (i_mem_load),
        .i_mem_addr     (i_mem_addr),
        .i_sbyte        (i_sbyte),
        .i_ubyte        (i_ubyte),
        .i_shalf        (i_shalf),
        .i_uhalf        (i_uhalf),
        .o_valid        (o_valid),
        .o_irq          (o_irq),
        .o_fiq          (o_fiq),
        .o_swi          (o_swi),
        .o_instr_abort  (o_instr_abort),
        .o_und          (o_und),
        .o_mem_fault    (o_mem_fault),
        .lane           (lane_bus.ctrl)
);

// ----------------------------------------
// Datapaths.
// ----------------------------------------

mem_payload_regs u_payload
(
        .i_clk              (i_clk),
        .i_alu_result       (i_alu_result),
        .i_flags            (i_flags),
        .i_pc_plus_8        (i_pc_plus_8),
        .i_dest_idx         (i_dest_idx),
        .i_mem_srcdest_idx  (i_mem_srcdest_idx),
        .o_alu_result       (o_alu_result),
        .o_flags            (o_flags),
        .o_pc_plus_8        (o_pc_plus_8),
        .o_dest_idx         (o_dest_idx),
        .o_mem_srcdest_idx  (o_mem_srcdest_idx),
        .o_mem_load         (o_mem_load),
        .lane               (lane_bus.lane)
);

// Rotate and extend the cache word.
load_align u_align
(
        .i_clk                (i_clk),
        .i_mem_rd_data        (i_mem_rd_data),
        .i_mem_srcdest_value  (i_mem_srcdest_value),
        .o_mem_rd_data        (o_mem_rd_data),
        .lane                 (lane_bus.lane)
);

endmodule

`default_nettype wire

// File: testbench/mem_stage_chk.sv
`default_nettype none

// Assertion checker for the memory stage, bound to mem_stage_top.
module mem_stage_chk
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,
        input  logic                    i_stall,
        input  logic                    i_valid,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        input  logic                    i_swi,
        input  logic                    i_instr_abort,
        input  logic                    i_und,
        input  mem_pkg::fault_t         i_mem_fault,
        input  logic                    i_mem_load,
        input  mem_pkg::byte_off_t      i_mem_addr,
        input  logic                    i_sbyte,
        input  logic                    i_ubyte,
        input  logic                    i_shalf,
        input  logic                    i_uhalf,
        input  mem_pkg::word_t          i_alu_result,
        input  mem_pkg::flags_t         i_flags,
        input  mem_pkg::word_t          i_pc_plus_8,
        input  mem_pkg::reg_idx_t       i_dest_idx,
        input  mem_pkg::reg_idx_t       i_mem_srcdest_idx,
        input  mem_pkg::word_t          i_mem_rd_data,
        input  mem_pkg::word_t          i_mem_srcdest_value,
        input  logic                    o_valid,
        input  logic                    o_irq,
        input  logic                    o_fiq,
        input  logic                    o_swi,
        input  logic                    o_instr_abort,
        input  logic                    o_und,
        input  mem_pkg::fault_t         o_mem_fault,
        input  mem_pkg::word_t          o_alu_result,
        input  mem_pkg::flags_t         o_flags,
        input  mem_pkg::word_t          o_pc_plus_8,
        input  mem_pkg::reg_idx_t       o_dest_idx,
        input  mem_pkg::reg_idx_t       o_mem_srcdest_idx,
        input  logic                    o_mem_load,
        input  mem_pkg::word_t          o_mem_rd_data
);

timeunit 1ns;
timeprecision 1ps;

// One sticky flag per assertion, read by the testbench.
logic fail_reset = 1'b0;
logic fail_clear = 1'b0;
logic fail_cap_ctrl = 1'b0;
logic fail_cap_data = 1'b0;
logic fail_stall = 1'b0;
logic fail_align = 1'b0;
logic fail_pass = 1'b0;
logic fail_flag;

// Stage moves forward this cycle.
logic clean;

// Valid, exceptions and fault all dropped.
logic quiet;

assign fail_flag = fail_reset | fail_clear | fail_cap_ctrl | fail_cap_data |
                   fail_stall | fail_align | fail_pass;
assign clean = !i_reset && !i_clear && !i_stall;
assign quiet = !o_valid && !o_irq && !o_fiq && !o_swi && !o_instr_abort &&
               !o_und && (o_mem_fault == 2'd0);

// Expected aligned word.
// Shift the addressed lane down, then extend by strobe priority.
function automatic logic [31:0] expected_rd_data
(
        input logic [31:0] rd,
        input logic [31:0] src,
        input logic [1:0]  off,
        input logic        ld,
        input logic        sb,
        input logic        ub,
        input logic        sh,
        input logic        uh
);
        logic [31:0] lane_b;
        logic [31:0] lane_h;
        lane_b = rd >> {off, 3'b000};
        lane_h = rd >> {off[1], 4'b0000};
        if ( !ld )
                return src;
        else if ( ub )
                return {24'd0, lane_b[7:0]};
        else if ( sb )
                return {{24{lane_b[7]}}, lane_b[7:0]};
        else if ( sh )
                return {{16{lane_h[15]}}, lane_h[15:0]};
        else if ( uh )
                return {16'd0, lane_h[15:0]};
        else
                return rd;
endfunction

// ----------------------------------------
// Reset and clear.
// ----------------------------------------

a_reset: assert property (@(posedge i_clk) i_reset |=> quiet)
else
begin
        fail_reset = 1'b1;
        $error("control outputs not low after reset");
end

// Clear wins over stall.
a_clear: assert property (@(posedge i_clk) (!i_reset && i_clear) |=> quiet)
else
begin
        fail_clear = 1'b1;
        $error("control outputs not low after clear");
end

// ----------------------------------------
// Capture and stall.
// ----------------------------------------

a_cap_ctrl: assert property (@(posedge i_clk) clean |=>
        o_valid == $past(i_valid) && o_irq == $past(i_irq) &&
        o_fiq == $past(i_fiq) && o_swi == $past(i_swi) &&
        o_instr_abort == $past(i_instr_abort) && o_und == $past(i_und) &&
        o_mem_fault == $past(i_mem_fault))
else
begin
        fail_cap_ctrl = 1'b1;
        $error("control outputs not captured");
end

a_cap_data: assert property (@(posedge i_clk) clean |=>
        o_alu_result == $past(i_alu_result) && o_flags == $past(i_flags) &&
        o_pc_plus_8 == $past(i_pc_plus_8) && o_dest_idx == $past(i_dest_idx) &&
        o_mem_srcdest_idx == $past(i_mem_srcdest_idx) &&
        o_mem_load == $past(i_mem_load))
else
begin
        fail_cap_data = 1'b1;
        $error("payload outputs not captured");
end

// Bubble out while everything else holds.
a_stall: assert property (@(posedge i_clk) (!i_reset && !i_clear && i_stall) |=>
        !o_valid && $stable(o_irq) && $stable(o_fiq) && $stable(o_swi) &&
        $stable(o_instr_abort) && $stable(o_und) && $stable(o_mem_fault) &&
        $stable(o_alu_result) && $stable(o_flags) && $stable(o_pc_plus_8) &&
        $stable(o_dest_idx) && $stable(o_mem_srcdest_idx) &&
        $stable(o_mem_load) && $stable(o_mem_rd_data))
else
begin
        fail_stall = 1'b1;
        $error("outputs moved under stall");
end

// ----------------------------------------
// Load alignment.
// ----------------------------------------

a_align: assert property (@(posedge i_clk) clean ##1 clean |=>
        o_mem_rd_data == expected_rd_data($past(i_mem_rd_data),
                $past(i_mem_srcdest_value), $past(i_mem_addr), $past(i_mem_load),
                $past(i_sbyte), $past(i_ubyte), $past(i_shalf), $past(i_uhalf)))
else
begin
        fail_align = 1'b1;
        $error("aligned read data mismatch");
end

// Strobes are ignored when not a load.
a_pass: assert property (@(posedge i_clk) clean ##1 (clean && !i_mem_load) |=>
        o_mem_rd_data == $past(i_mem_srcdest_value))
else
begin
        fail_pass = 1'b1;
        $error("srcdest value not passed through");
end

endmodule

bind mem_stage_top mem_stage_chk u_chk (.*);

`default_nettype wire

// File: testbench/tb_mem_stage.sv
`default_nettype none

// Testbench for the memory stage.
// Random pipeline traffic; the bound checker does the comparing.
module tb_mem_stage;

timeunit 1ns;
timeprecision 1ps;

// ----------------------------------------
// Run constants.
// ----------------------------------------

localparam int CLK_HALF        = 20;
localparam int RESET_CYCLES    = 16;
localparam int TEST_CYCLES     = 2000;
localparam int DRIVE_DELAY     = 2;

// Test length plus a quarter margin.
localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

// DUT inputs.
logic                   i_clk = 1'b0;
logic                   i_reset;
logic                   i_clear;
logic                   i_stall;
logic                   i_valid;
logic                   i_irq;
logic                   i_fiq;
logic                   i_swi;
logic                   i_instr_abort;
logic                   i_und;
mem_pkg::fault_t        i_mem_fault;
logic                   i_mem_load;
mem_pkg::byte_off_t     i_mem_addr;
logic                   i_sbyte;
logic                   i_ubyte;
logic                   i_shalf;
logic                   i_uhalf;
mem_pkg::word_t         i_alu_result;
mem_pkg::flags_t        i_flags;
mem_pkg::word_t         i_pc_plus_8;
mem_pkg::reg_idx_t      i_dest_idx;
mem_pkg::reg_idx_t      i_mem_srcdest_idx;
mem_pkg::word_t         i_mem_rd_data;
mem_pkg::word_t         i_mem_srcdest_value;

// DUT outputs.
logic                   o_valid;
logic                   o_irq;
logic                   o_fiq;
logic                   o_swi;
logic                   o_instr_abort;
logic                   o_und;
mem_pkg::fault_t        o_mem_fault;
mem_pkg::word_t         o_alu_result;
mem_pkg::flags_t        o_flags;
mem_pkg::word_t         o_pc_plus_8;
mem_pkg::reg_idx_t      o_dest_idx;
mem_pkg::reg_idx_t      o_mem_srcdest_idx;
logic                   o_mem_load;
mem_pkg::word_t         o_mem_rd_data;

// Random state.
integer                 seed = 32'h6923;

// Checker failures seen.
int                     fail_count = 0;

mem_stage_top uut (.*);

// 40 ns period.
always #CLK_HALF i_clk = ~i_clk;

function automatic logic [31:0] next_word();
        return $random(seed);
endfunction

// Quiet inputs with no stall and no clear.
task automatic drive_idle();
        i_clear             = 1'b0;
        i_stall             = 1'b0;
        i_valid             = 1'b0;
        i_irq               = 1'b0;
        i_fiq               = 1'b0;
        i_swi               = 1'b0;
        i_instr_abort       = 1'b0;
        i_und               = 1'b0;
        i_mem_fault         = '0;
        i_mem_load          = 1'b0;
        i_mem_addr          = '0;
        {i_sbyte, i_ubyte, i_shalf, i_uhalf} = 4'b0000;
        i_alu_result        = '0;
        i_flags             = '0;
        i_pc_plus_8         = '0;
        i_dest_idx          = '0;
        i_mem_srcdest_idx   = '0;
        i_mem_rd_data       = '0;
        i_mem_srcdest_value = '0;
endtask

task automatic randomize_inputs();
        logic [31:0] r;
        logic [2:0]  pick;
        r = next_word();
        // Clear about 1 in 16, stall about 1 in 5.
        i_clear = (r[3:0] == 4'd0);
        i_stall = ((r[31:8] % 24'd5) == 24'd0);
        // Pick 4 shifts the strobe out, so no size is set.
        pick = 3'(r[7:4] % 4'd5);
        {i_sbyte, i_ubyte, i_shalf, i_uhalf} = 4'b0001 << pick;
        r = next_word();
        i_valid             = r[0];
        i_irq               = r[1];
        i_fiq               = r[2];
        i_swi               = r[3];
        i_instr_abort       = r[4];
        i_und               = r[5];
        i_mem_fault         = r[7:6];
        i_mem_load          = r[8];
        i_mem_addr          = r[10:9];
        i_alu_result        = next_word();
        i_flags             = next_word();
        i_pc_plus_8         = next_word();
        i_mem_rd_data       = next_word();
        i_mem_srcdest_value = next_word();
        // Indexes stay inside the register file.
        i_dest_idx          = mem_pkg::reg_idx_t'(next_word() % 32'(mem_pkg::PHY_REGS));
        i_mem_srcdest_idx   = mem_pkg::reg_idx_t'(next_word() % 32'(mem_pkg::PHY_REGS));
endtask

// ----------------------------------------
// Stimulus.
// ----------------------------------------

initial
begin
        drive_idle();
        i_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DELAY;
        // First cycle out of reset is a clean capture.
        i_reset = 1'b0;
        repeat (TEST_CYCLES)
        begin
                @(posedge i_clk);
                #DRIVE_DELAY;
                randomize_inputs();
        end
        @(posedge i_clk);
        @(negedge i_clk);
        // Flag watcher for this edge has already run.
        #1;
        if ( fail_count == 0 )
        begin
                $display("TEST OK");
                $finish;
        end
        else
        begin
                $display("TEST FAILED");
                $fatal(1, "checker failures were counted");
        end
end

// Checker flag is sampled away from the active edge.
always @(negedge i_clk)
begin
        if ( uut.u_chk.fail_flag )
        begin
                fail_count = fail_count + 1;
                $display("ERROR %0t: assertion failed", $time);
                $display("TEST FAILED");
                $fatal(1, "stopping at first checker failure");
        end
end

// Watchdog.
initial
begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("timeout: run did not reach its end");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
end

endmodule

`default_nettype wire

// File: list.f
rtl/mem_pkg.sv
rtl/mem_lane_if.sv
rtl/mem_stage_ctrl.sv
rtl/mem_payload_regs.sv
rtl/load_align.sv
rtl/mem_stage_top.sv
testbench/mem_stage_chk.sv
testbench/tb_mem_stage.sv

// File: Makefile
# Verilator build and run for the memory stage testbench.

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_mem_stage \
		-f list.f -o tb_mem_stage

# Pass only if the log holds the pass line.
run: compile
	./obj_dir/tb_mem_stage | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
